//--- hdl/proc_pkg.sv
`default_nettype none

package proc_pkg;

   //////////////////////////////////////////////////////////////////////
   // Widths and constants
   //////////////////////////////////////////////////////////////////////

   typedef logic [31:0] word_t;
   typedef logic [31:0] pc_t;
   typedef logic [4:0]  reg_idx_t;
   // Bit 3 is the lane at the lowest byte address
   typedef logic [3:0]  byte_en_t;
   typedef logic [1:0]  fwd_sel_t;

   localparam pc_t      RESET_PC = 32'h0000_0000;
   localparam pc_t      PC_STEP  = 32'd4;
   localparam int       NUM_REGS = 32;

   localparam byte_en_t BE_WORD = 4'hF;
   localparam byte_en_t BE_HALF = 4'hC;
   localparam byte_en_t BE_BYTE = 4'h8;

   // Instruction field positions
   localparam int OPC_MSB = 31;
   localparam int OPC_LSB = 26;
   localparam int RS_MSB  = 25;
   localparam int RS_LSB  = 21;
   localparam int RT_MSB  = 20;
   localparam int RT_LSB  = 16;
   localparam int RD_MSB  = 15;
   localparam int RD_LSB  = 11;
   localparam int IMM_W   = 16;

   // Execute operand sources
   localparam fwd_sel_t FWD_REG    = 2'd0;
   localparam fwd_sel_t FWD_EX_MEM = 2'd1;
   localparam fwd_sel_t FWD_WB     = 2'd2;

   //////////////////////////////////////////////////////////////////////
   // Encodings
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [5:0] {
      OP_HALT    = 6'd0,
      OP_NOP     = 6'd1,
      OP_ADD     = 6'd16,
      OP_SUB     = 6'd17,
      OP_AND     = 6'd18,
      OP_OR      = 6'd19,
      OP_XOR     = 6'd20,
      OP_ADDI    = 6'd24,
      OP_LD_BASE = 6'd32,  // Low two bits carry the granularity
      OP_ST_BASE = 6'd36
   } opcode_e;

   localparam word_t NOP_INST = {OP_NOP, 26'd0};

   typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;

   typedef enum logic [1:0] {
      GRAN_WORD = 2'b00,
      GRAN_BYTE = 2'b01,
      GRAN_HALF = 2'b10,
      GRAN_BAD  = 2'b11
   } gran_e;

   //////////////////////////////////////////////////////////////////////
   // Stage records
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic    reg_write;
      logic    mem_read;
      logic    mem_write;
      logic    mem_to_reg;
      logic    alu_src;
      alu_op_e alu_op;
      gran_e   gran;
      logic    halt;
      logic    illegal;
   } ctrl_t;

   typedef struct packed {
      logic     we;
      reg_idx_t idx;
      word_t    data;
   } wb_t;

   typedef struct packed {
      ctrl_t    ctrl;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t dst;
      word_t    rs_val;
      word_t    rt_val;
      word_t    imm;
   } id_ex_t;

   typedef struct packed {
      ctrl_t    ctrl;
      reg_idx_t dst;
      word_t    alu_res;
      word_t    st_data;
   } ex_mem_t;

   typedef struct packed {
      logic     reg_write;
      logic     mem_to_reg;
      logic     halt;
      reg_idx_t idx;
      word_t    alu_res;
      word_t    ld_data;
   } mem_wb_t;

endpackage

`default_nettype wire

//--- hdl/fetch_stage.sv
`default_nettype none

module fetch_stage (
   input  logic            clk,
   input  logic            rst_n,
   input  proc_pkg::word_t inst_i,
   input  logic            stall_i,
   input  logic            halt_seen_i,
   output proc_pkg::pc_t   iaddr_o,
   output proc_pkg::word_t if_inst_o
);

   logic hold;

   // Load-use stall or a HALT further down keeps fetch where it is
   assign hold = stall_i | halt_seen_i;

   // Program counter
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         iaddr_o <= proc_pkg::RESET_PC;
      end else if (!hold) begin
         iaddr_o <= iaddr_o + proc_pkg::PC_STEP;
      end
   end

   // IF/ID instruction register
   // A held HALT recirculates here, so it keeps flowing into decode
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         if_inst_o <= proc_pkg::NOP_INST;
      end else if (!hold) begin
         if_inst_o <= inst_i;
      end
   end

endmodule

`default_nettype wire

//--- hdl/decode_ctrl.sv
`default_nettype none

module decode_ctrl (
   input  proc_pkg::opcode_e opcode_i,
   output proc_pkg::ctrl_t   ctrl_o
);

   logic [5:0] op_bits;

   assign op_bits = opcode_i;

   always_comb begin
      ctrl_o = '0;
      if ({op_bits[5:2], 2'b00} == proc_pkg::OP_LD_BASE) begin
         // Loads write rt from rs plus immediate
         ctrl_o.reg_write  = 1'b1;
         ctrl_o.mem_read   = 1'b1;
         ctrl_o.mem_to_reg = 1'b1;
         ctrl_o.alu_src    = 1'b1;
         ctrl_o.alu_op     = proc_pkg::ALU_ADD;
         ctrl_o.gran       = proc_pkg::gran_e'(op_bits[1:0]);
      end else if ({op_bits[5:2], 2'b00} == proc_pkg::OP_ST_BASE) begin
         ctrl_o.mem_write  = 1'b1;
         ctrl_o.alu_src    = 1'b1;
         ctrl_o.alu_op     = proc_pkg::ALU_ADD;
         ctrl_o.gran       = proc_pkg::gran_e'(op_bits[1:0]);
      end else begin
         case (opcode_i)
            proc_pkg::OP_HALT: ctrl_o.halt = 1'b1;
            proc_pkg::OP_NOP: begin
               // All control low
            end
            proc_pkg::OP_ADD,
            proc_pkg::OP_SUB,
            proc_pkg::OP_AND,
            proc_pkg::OP_OR,
            proc_pkg::OP_XOR: begin
               ctrl_o.reg_write = 1'b1;
               ctrl_o.alu_op    = proc_pkg::alu_op_e'(op_bits[2:0]);
            end
            proc_pkg::OP_ADDI: begin
               ctrl_o.reg_write = 1'b1;
               ctrl_o.alu_src   = 1'b1;
               ctrl_o.alu_op    = proc_pkg::ALU_ADD;
            end
            // Behaves as a NOP but gets reported
            default: ctrl_o.illegal = 1'b1;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`default_nettype none

module reg_file (
   input  logic                clk,
   input  logic                rst_n,
   input  proc_pkg::wb_t       wb_i,
   input  proc_pkg::reg_idx_t  ra_i,
   input  proc_pkg::reg_idx_t  rb_i,
   output proc_pkg::word_t     rdata_a_o,
   output proc_pkg::word_t     rdata_b_o
);

   proc_pkg::word_t regs [proc_pkg::NUM_REGS];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < proc_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_i.we) begin
         regs[wb_i.idx] <= wb_i.data;
      end
   end

   // Write-through, decode sees the value retiring this cycle
   assign rdata_a_o = (wb_i.we && wb_i.idx == ra_i) ? wb_i.data : regs[ra_i];
   assign rdata_b_o = (wb_i.we && wb_i.idx == rb_i) ? wb_i.data : regs[rb_i];

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`default_nettype none

module decode_stage (
   input  logic             clk,
   input  logic             rst_n,
   input  proc_pkg::word_t  if_inst_i,
   input  logic             stall_i,
   input  proc_pkg::wb_t    wb_i,
   output proc_pkg::id_ex_t id_ex_o,
   output logic             halt_seen_o
);

   proc_pkg::opcode_e  opcode;
   proc_pkg::ctrl_t    ctrl;
   proc_pkg::reg_idx_t rs, rt, rd;
   proc_pkg::word_t    rs_val, rt_val;
   proc_pkg::id_ex_t   id_ex_d;

   // Field extraction
   assign opcode = proc_pkg::opcode_e'(if_inst_i[proc_pkg::OPC_MSB:proc_pkg::OPC_LSB]);
   assign rs     = if_inst_i[proc_pkg::RS_MSB:proc_pkg::RS_LSB];
   assign rt     = if_inst_i[proc_pkg::RT_MSB:proc_pkg::RT_LSB];
   assign rd     = if_inst_i[proc_pkg::RD_MSB:proc_pkg::RD_LSB];

   decode_ctrl u_ctrl (
      .opcode_i (opcode),
      .ctrl_o   (ctrl)
   );

   reg_file u_rf (
      .clk       (clk),
      .rst_n     (rst_n),
      .wb_i      (wb_i),
      .ra_i      (rs),
      .rb_i      (rt),
      .rdata_a_o (rs_val),
      .rdata_b_o (rt_val)
   );

   always_comb begin
      id_ex_d.ctrl   = ctrl;
      id_ex_d.rs     = rs;
      id_ex_d.rt     = rt;
      // R-format writes rd, the immediate forms write rt
      id_ex_d.dst    = ctrl.alu_src ? rt : rd;
      id_ex_d.rs_val = rs_val;
      id_ex_d.rt_val = rt_val;
      id_ex_d.imm    = {{(32 - proc_pkg::IMM_W){if_inst_i[proc_pkg::IMM_W-1]}},
                        if_inst_i[proc_pkg::IMM_W-1:0]};
   end

   // ID/EX register, bubble on a load-use stall
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         id_ex_o <= '0;
      end else if (stall_i) begin
         id_ex_o <= '0;
      end else begin
         id_ex_o <= id_ex_d;
      end
   end

   assign halt_seen_o = ctrl.halt | id_ex_o.ctrl.halt;

endmodule

`default_nettype wire

//--- hdl/hazard_forward.sv
`default_nettype none

module hazard_forward (
   input  proc_pkg::word_t    if_inst_i,
   input  proc_pkg::id_ex_t   id_ex_i,
   input  proc_pkg::ex_mem_t  ex_mem_i,
   input  proc_pkg::wb_t      wb_i,
   output logic               stall_o,
   output proc_pkg::fwd_sel_t fwd_a_o,
   output proc_pkg::fwd_sel_t fwd_b_o
);

   proc_pkg::reg_idx_t if_rs, if_rt;
   logic               ex_mem_fwd;

   assign if_rs = if_inst_i[proc_pkg::RS_MSB:proc_pkg::RS_LSB];
   assign if_rt = if_inst_i[proc_pkg::RT_MSB:proc_pkg::RT_LSB];

   // Load in execute feeding the instruction in decode
   assign stall_o = id_ex_i.ctrl.mem_read && (id_ex_i.dst == if_rs || id_ex_i.dst == if_rt);

   // A load's data isn't in EX/MEM yet, only its address
   assign ex_mem_fwd = ex_mem_i.ctrl.reg_write & ~ex_mem_i.ctrl.mem_read;

   // Youngest producer wins
   function automatic proc_pkg::fwd_sel_t pick_src(input proc_pkg::reg_idx_t src);
      proc_pkg::fwd_sel_t sel;
      if (ex_mem_fwd && ex_mem_i.dst == src) begin
         sel = proc_pkg::FWD_EX_MEM;
      end else if (wb_i.we && wb_i.idx == src) begin
         sel = proc_pkg::FWD_WB;
      end else begin
         sel = proc_pkg::FWD_REG;
      end
      return sel;
   endfunction

   always_comb begin
      fwd_a_o = pick_src(id_ex_i.rs);
      fwd_b_o = pick_src(id_ex_i.rt);
   end

endmodule

`default_nettype wire

//--- hdl/exec_stage.sv
`default_nettype none

module exec_stage (
   input  logic               clk,
   input  logic               rst_n,
   input  proc_pkg::id_ex_t   id_ex_i,
   input  proc_pkg::fwd_sel_t fwd_a_i,
   input  proc_pkg::fwd_sel_t fwd_b_i,
   input  proc_pkg::wb_t      wb_i,
   output proc_pkg::ex_mem_t  ex_mem_o
);

   proc_pkg::word_t   op_a, rt_fwd, op_b, alu_res;
   proc_pkg::ex_mem_t ex_mem_d;

   function automatic proc_pkg::word_t fwd_mux(input proc_pkg::fwd_sel_t sel,
                                               input proc_pkg::word_t    reg_val,
                                               input proc_pkg::word_t    ex_mem_val,
                                               input proc_pkg::word_t    wb_val);
      case (sel)
         proc_pkg::FWD_EX_MEM: return ex_mem_val;
         proc_pkg::FWD_WB:     return wb_val;
         default:              return reg_val;
      endcase
   endfunction

   assign op_a   = fwd_mux(fwd_a_i, id_ex_i.rs_val, ex_mem_o.alu_res, wb_i.data);
   assign rt_fwd = fwd_mux(fwd_b_i, id_ex_i.rt_val, ex_mem_o.alu_res, wb_i.data);
   assign op_b   = id_ex_i.ctrl.alu_src ? id_ex_i.imm : rt_fwd;

   always_comb begin
      case (id_ex_i.ctrl.alu_op)
         proc_pkg::ALU_SUB: alu_res = op_a - op_b;
         proc_pkg::ALU_AND: alu_res = op_a & op_b;
         proc_pkg::ALU_OR:  alu_res = op_a | op_b;
         proc_pkg::ALU_XOR: alu_res = op_a ^ op_b;
         default:           alu_res = op_a + op_b;
      endcase
   end

   always_comb begin
      ex_mem_d.ctrl    = id_ex_i.ctrl;
      ex_mem_d.dst     = id_ex_i.dst;
      ex_mem_d.alu_res = alu_res;
      // Store data is the forwarded rt, never the immediate
      ex_mem_d.st_data = rt_fwd;
   end

   // EX/MEM register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex_mem_o <= '0;
      end else begin
         ex_mem_o <= ex_mem_d;
      end
   end

endmodule

`default_nettype wire

//--- hdl/mem_stage.sv
`default_nettype none

module mem_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  proc_pkg::ex_mem_t ex_mem_i,
   input  proc_pkg::word_t   data_mem_to_proc_i,
   output proc_pkg::word_t   daddr_o,
   output proc_pkg::word_t   data_proc_to_mem_o,
   output proc_pkg::byte_en_t we_o,
   output proc_pkg::byte_en_t re_o,
   output logic              err_o,
   output logic              halt_o,
   output proc_pkg::wb_t     wb_o
);

   proc_pkg::byte_en_t lanes;
   proc_pkg::mem_wb_t  mem_wb_q;

   assign daddr_o            = ex_mem_i.alu_res;
   assign data_proc_to_mem_o = ex_mem_i.st_data;

   // Big-endian lanes, offset 0 is the top lane
   always_comb begin
      case (ex_mem_i.ctrl.gran)
         proc_pkg::GRAN_WORD: lanes = proc_pkg::BE_WORD;
         proc_pkg::GRAN_HALF: lanes = proc_pkg::BE_HALF >> ex_mem_i.alu_res[1:0];
         proc_pkg::GRAN_BYTE: lanes = proc_pkg::BE_BYTE >> ex_mem_i.alu_res[1:0];
         default:             lanes = '0;
      endcase
   end

   assign we_o  = {4{ex_mem_i.ctrl.mem_write}} & lanes;
   assign re_o  = {4{ex_mem_i.ctrl.mem_read}} & lanes;
   assign err_o = (ex_mem_i.ctrl.gran == proc_pkg::GRAN_BAD) | ex_mem_i.ctrl.illegal;

   // MEM/WB register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem_wb_q <= '0;
      end else begin
         mem_wb_q.reg_write  <= ex_mem_i.ctrl.reg_write;
         mem_wb_q.mem_to_reg <= ex_mem_i.ctrl.mem_to_reg;
         mem_wb_q.halt       <= ex_mem_i.ctrl.halt;
         mem_wb_q.idx        <= ex_mem_i.dst;
         mem_wb_q.alu_res    <= ex_mem_i.alu_res;
         mem_wb_q.ld_data    <= data_mem_to_proc_i;
      end
   end

   // Writeback mux
   assign wb_o.we   = mem_wb_q.reg_write;
   assign wb_o.idx  = mem_wb_q.idx;
   assign wb_o.data = mem_wb_q.mem_to_reg ? mem_wb_q.ld_data : mem_wb_q.alu_res;

   assign halt_o = mem_wb_q.halt;

endmodule

`default_nettype wire

//--- hdl/proc_top.sv
`default_nettype none

module proc_top (
   input  logic               clk,
   input  logic               rst_n,
   input  proc_pkg::word_t    inst_i,
   input  proc_pkg::word_t    data_mem_to_proc_i,
   output proc_pkg::pc_t      iaddr_o,
   output proc_pkg::word_t    daddr_o,
   output proc_pkg::word_t    data_proc_to_mem_o,
   output proc_pkg::byte_en_t we_o,
   output proc_pkg::byte_en_t re_o,
   output logic               err_o,
   output logic               halt_o
);

   //////////////////////////////////////////////////////////////////////
   // Stage wires
   //////////////////////////////////////////////////////////////////////

   proc_pkg::word_t    if_inst;
   proc_pkg::id_ex_t   id_ex;
   proc_pkg::ex_mem_t  ex_mem;
   proc_pkg::wb_t      wb;
   proc_pkg::fwd_sel_t fwd_a, fwd_b;
   logic               stall, halt_seen, halt_any;

   // HALT from decode through writeback freezes the PC
   assign halt_any = halt_seen | halt_o;

   //////////////////////////////////////////////////////////////////////
   // Pipeline
   //////////////////////////////////////////////////////////////////////

   fetch_stage u_fetch (
      .clk(clk), .rst_n(rst_n), .inst_i(inst_i), .stall_i(stall),
      .halt_seen_i(halt_any), .iaddr_o(iaddr_o), .if_inst_o(if_inst)
   );

   decode_stage u_decode (
      .clk(clk), .rst_n(rst_n), .if_inst_i(if_inst), .stall_i(stall),
      .wb_i(wb), .id_ex_o(id_ex), .halt_seen_o(halt_seen)
   );

   hazard_forward u_hazard (
      .if_inst_i(if_inst), .id_ex_i(id_ex), .ex_mem_i(ex_mem), .wb_i(wb),
      .stall_o(stall), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b)
   );

   exec_stage u_exec (
      .clk(clk), .rst_n(rst_n), .id_ex_i(id_ex), .fwd_a_i(fwd_a),
      .fwd_b_i(fwd_b), .wb_i(wb), .ex_mem_o(ex_mem)
   );

   mem_stage u_mem (
      .clk(clk), .rst_n(rst_n), .ex_mem_i(ex_mem),
      .data_mem_to_proc_i(data_mem_to_proc_i), .daddr_o(daddr_o),
      .data_proc_to_mem_o(data_proc_to_mem_o), .we_o(we_o), .re_o(re_o),
      .err_o(err_o), .halt_o(halt_o), .wb_o(wb)
   );

endmodule

`default_nettype wire

//--- test/proc_checker.sv
`default_nettype none

module proc_checker (
   input logic               clk,
   input logic               rst_n,
   input proc_pkg::pc_t      iaddr_i,
   input proc_pkg::byte_en_t we_i,
   input proc_pkg::byte_en_t re_i,
   input logic               halt_i
);

   //////////////////////////////////////////////////////////////////////
   // Data port
   //////////////////////////////////////////////////////////////////////

   // A single access is either a load or a store
   assert property (@(posedge clk) disable iff (!rst_n)
      !(we_i != 4'h0 && re_i != 4'h0))
      else $error("we_o and re_o active in the same cycle");

   // Word, any half position or any byte position
   assert property (@(posedge clk) disable iff (!rst_n)
      we_i inside {4'h0, 4'hF, 4'hC, 4'h6, 4'h3, 4'h8, 4'h4, 4'h2, 4'h1})
      else $error("we_o carries an illegal lane mask");

   //////////////////////////////////////////////////////////////////////
   // Halt
   //////////////////////////////////////////////////////////////////////

   // Sticky until the next reset
   assert property (@(posedge clk) disable iff (!rst_n) halt_i |=> halt_i)
      else $error("halt_o fell while out of reset");

   assert property (@(posedge clk) disable iff (!rst_n) halt_i |=> $stable(iaddr_i))
      else $error("iaddr_o moved after halt");

   assert property (@(posedge clk) disable iff (!rst_n) halt_i |-> we_i == 4'h0)
      else $error("store issued after halt");

endmodule

bind proc_top proc_checker u_checker (
   .clk     (clk),
   .rst_n   (rst_n),
   .iaddr_i (iaddr_o),
   .we_i    (we_o),
   .re_i    (re_o),
   .halt_i  (halt_o)
);

`default_nettype wire

//--- test/proc_tb.sv
`default_nettype none

module proc_tb;

   typedef struct packed {
      proc_pkg::word_t    addr;
      proc_pkg::byte_en_t be;
      proc_pkg::word_t    data;
   } store_ev_t;

   typedef struct packed {
      proc_pkg::word_t    addr;
      proc_pkg::byte_en_t be;
   } load_ev_t;

   logic               clk;
   logic               rst_n;
   proc_pkg::word_t    inst_i;
   proc_pkg::word_t    data_mem_to_proc_i;
   proc_pkg::pc_t      iaddr_o;
   proc_pkg::word_t    daddr_o;
   proc_pkg::word_t    data_proc_to_mem_o;
   proc_pkg::byte_en_t we_o;
   proc_pkg::byte_en_t re_o;
   logic               err_o;
   logic               halt_o;

   proc_pkg::word_t rom [64];
   proc_pkg::word_t dmem [256];
   proc_pkg::word_t ref_mem [256];
   proc_pkg::word_t mreg [32];
   store_ev_t       exp_q [$];
   load_ev_t        ld_q [$];
   int              prog_len;
   int              exp_err;
   int              err_seen;
   int              stores_seen;
   int              errors;
   proc_pkg::pc_t   halt_addr;

   proc_top uut (.*);

   initial clk = 1'b0;
   always #4 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // Memories
   //////////////////////////////////////////////////////////////////////

   function automatic proc_pkg::word_t fill_word(input int i);
      return 32'h5A00_0000 + 32'(i) * 32'h0001_0203;
   endfunction

   // Lane bit 3 covers data bits 31:24
   function automatic proc_pkg::word_t lane_mask(input proc_pkg::byte_en_t be);
      return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
   endfunction

   assign inst_i = (iaddr_o < 32'd256) ? rom[iaddr_o[7:2]] : {proc_pkg::OP_HALT, 26'd0};
   assign data_mem_to_proc_i = (re_o != 4'h0) ? dmem[daddr_o[9:2]] : 32'h0;

   always @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 256; i++) begin
            dmem[i] <= fill_word(i);
         end
      end else if (we_o != 4'h0) begin
         dmem[daddr_o[9:2]] <= (dmem[daddr_o[9:2]] & ~lane_mask(we_o)) |
                               (data_proc_to_mem_o & lane_mask(we_o));
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Program builder and reference model
   //////////////////////////////////////////////////////////////////////

   function automatic proc_pkg::word_t sext(input logic [15:0] imm);
      return {{16{imm[15]}}, imm};
   endfunction

   // Byte k of a word sits at address offset k
   function automatic proc_pkg::byte_en_t lanes_for(input proc_pkg::gran_e g,
                                                    input logic [1:0]      off);
      proc_pkg::byte_en_t be;
      int                 first;
      int                 span;
      be = 4'h0;
      first = int'(off);
      case (g)
         proc_pkg::GRAN_WORD: begin
            first = 0;
            span = 4;
         end
         proc_pkg::GRAN_HALF: span = 2;
         proc_pkg::GRAN_BYTE: span = 1;
         default:             span = 0;
      endcase
      for (int k = 0; k < 4; k++) begin
         be = {be[2:0], (k >= first && k < first + span)};
      end
      return be;
   endfunction

   task automatic new_program();
      prog_len = 0;
      exp_err = 0;
      exp_q.delete();
      ld_q.delete();
      for (int i = 0; i < 64; i++) begin
         rom[i] = {proc_pkg::OP_HALT, 26'd0};
      end
      for (int i = 0; i < 32; i++) begin
         mreg[i] = 32'h0;
      end
      for (int i = 0; i < 256; i++) begin
         ref_mem[i] = fill_word(i);
      end
   endtask

   task automatic put_word(input proc_pkg::word_t w);
      rom[prog_len] = w;
      prog_len++;
   endtask

   task automatic emit_r(input proc_pkg::opcode_e op, input proc_pkg::reg_idx_t rd, rs, rt);
      proc_pkg::word_t a;
      proc_pkg::word_t b;
      put_word({op, rs, rt, rd, 11'd0});
      a = mreg[rs];
      b = mreg[rt];
      case (op)
         proc_pkg::OP_ADD: mreg[rd] = a + b;
         proc_pkg::OP_SUB: mreg[rd] = a - b;
         proc_pkg::OP_AND: mreg[rd] = a & b;
         proc_pkg::OP_OR:  mreg[rd] = a | b;
         default:          mreg[rd] = a ^ b;
      endcase
   endtask

   task automatic emit_addi(input proc_pkg::reg_idx_t rt, rs, input logic [15:0] imm);
      put_word({proc_pkg::OP_ADDI, rs, rt, imm});
      mreg[rt] = mreg[rs] + sext(imm);
   endtask

   task automatic emit_load(input proc_pkg::reg_idx_t rt, rs, input logic [15:0] imm);
      proc_pkg::word_t addr;
      load_ev_t        ev;
      put_word({6'(proc_pkg::OP_LD_BASE) | {4'd0, 2'(proc_pkg::GRAN_WORD)}, rs, rt, imm});
      addr = mreg[rs] + sext(imm);
      ev.addr = addr;
      ev.be = lanes_for(proc_pkg::GRAN_WORD, addr[1:0]);
      ld_q.push_back(ev);
      mreg[rt] = ref_mem[addr[9:2]];
   endtask

   task automatic emit_store(input proc_pkg::gran_e g, input proc_pkg::reg_idx_t rt, rs,
                             input logic [15:0] imm);
      proc_pkg::word_t addr;
      store_ev_t       ev;
      put_word({6'(proc_pkg::OP_ST_BASE) | {4'd0, 2'(g)}, rs, rt, imm});
      addr = mreg[rs] + sext(imm);
      if (g == proc_pkg::GRAN_BAD) begin
         exp_err++;
      end else begin
         ev.addr = addr;
         ev.be = lanes_for(g, addr[1:0]);
         ev.data = mreg[rt];
         exp_q.push_back(ev);
         ref_mem[addr[9:2]] = (ref_mem[addr[9:2]] & ~lane_mask(ev.be)) |
                              (ev.data & lane_mask(ev.be));
      end
   endtask

   task automatic emit_illegal(input logic [5:0] op);
      put_word({op, 26'h0});
      exp_err++;
   endtask

   // Fetch stops right behind the HALT
   task automatic emit_halt();
      halt_addr = proc_pkg::pc_t'(prog_len * 4);
      put_word({proc_pkg::OP_HALT, 26'd0});
   endtask

   //////////////////////////////////////////////////////////////////////
   // Checking
   //////////////////////////////////////////////////////////////////////

   task automatic check_cycle();
      store_ev_t ev;
      load_ev_t  lev;
      assert (!(err_o && (we_o != 4'h0 || re_o != 4'h0))) else begin
         errors++;
         $display("ERROR we_o %h re_o %h while err_o is set", we_o, re_o);
      end
      if (err_o) begin
         err_seen++;
      end
      if (re_o != 4'h0) begin
         assert (ld_q.size() > 0) else begin
            errors++;
            $display("Unexpected load from address %h", daddr_o);
         end
         if (ld_q.size() > 0) begin
            lev = ld_q.pop_front();
            assert (daddr_o == lev.addr) else begin
               errors++;
               $display("ERROR daddr_o got %h expected %h", daddr_o, lev.addr);
            end
            assert (re_o == lev.be) else begin
               errors++;
               $display("ERROR re_o got %h expected %h", re_o, lev.be);
            end
         end
      end
      if (we_o != 4'h0) begin
         stores_seen++;
         assert (exp_q.size() > 0) else begin
            errors++;
            $display("Unexpected store to address %h", daddr_o);
         end
         if (exp_q.size() > 0) begin
            ev = exp_q.pop_front();
            assert (daddr_o == ev.addr) else begin
               errors++;
               $display("ERROR daddr_o got %h expected %h", daddr_o, ev.addr);
            end
            assert (we_o == ev.be) else begin
               errors++;
               $display("ERROR we_o got %h expected %h", we_o, ev.be);
            end
            assert (data_proc_to_mem_o == ev.data) else begin
               errors++;
               $display("ERROR data_proc_to_mem_o got %h expected %h",
                        data_proc_to_mem_o, ev.data);
            end
         end
      end
   endtask

   task automatic run_program();
      int cycles;
      @(negedge clk);
      rst_n = 1'b0;
      err_seen = 0;
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      cycles = 0;
      while (!halt_o && cycles < 400) begin
         @(negedge clk);
         check_cycle();
         cycles++;
      end
      assert (halt_o) else begin
         errors++;
         $display("Timed out waiting for halt_o to rise");
      end
      // Pipeline should now sit frozen
      cycles = 0;
      while (halt_o && cycles < 12) begin
         @(negedge clk);
         check_cycle();
         assert (iaddr_o == halt_addr + 32'd4) else begin
            errors++;
            $display("ERROR iaddr_o got %h expected %h", iaddr_o, halt_addr + 32'd4);
         end
         cycles++;
      end
      assert (halt_o) else begin
         errors++;
         $display("halt_o dropped after it had risen");
      end
      assert (exp_q.size() == 0) else begin
         errors++;
         $display("%0d expected stores never appeared", exp_q.size());
      end
      assert (ld_q.size() == 0) else begin
         errors++;
         $display("%0d expected loads never appeared", ld_q.size());
      end
      assert (err_seen == exp_err) else begin
         errors++;
         $display("ERROR err_o cycles got %h expected %h", err_seen, exp_err);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////////////////////////

   task automatic test_alu_forwarding();
      new_program();
      emit_addi(5'd1, 5'd0, 16'($urandom));
      emit_addi(5'd2, 5'd1, 16'($urandom));
      emit_r(proc_pkg::OP_ADD, 5'd3, 5'd1, 5'd2);
      emit_r(proc_pkg::OP_SUB, 5'd4, 5'd3, 5'd1);
      emit_r(proc_pkg::OP_AND, 5'd5, 5'd4, 5'd3);
      emit_r(proc_pkg::OP_OR,  5'd6, 5'd5, 5'd2);
      emit_r(proc_pkg::OP_XOR, 5'd7, 5'd6, 5'd4);
      for (int r = 1; r <= 7; r++) begin
         emit_store(proc_pkg::GRAN_WORD, 5'(r), 5'd0, 16'(32'h200 + 4 * r));
      end
      emit_halt();
      run_program();
   endtask

   task automatic test_byte_lanes();
      new_program();
      emit_addi(5'd1, 5'd0, 16'h0040);
      emit_addi(5'd2, 5'd0, 16'($urandom));
      for (int off = 0; off < 4; off++) begin
         emit_store(proc_pkg::GRAN_HALF, 5'd2, 5'd1, 16'(off));
         emit_store(proc_pkg::GRAN_BYTE, 5'd2, 5'd1, 16'(8 + off));
      end
      emit_halt();
      run_program();
   endtask

   task automatic test_load_use();
      new_program();
      emit_addi(5'd5, 5'd0, 16'($urandom));
      emit_addi(5'd2, 5'd0, 16'h0080);
      emit_load(5'd3, 5'd2, 16'h0008);
      emit_r(proc_pkg::OP_ADD, 5'd4, 5'd3, 5'd5);
      emit_store(proc_pkg::GRAN_WORD, 5'd4, 5'd0, 16'h0100);
      emit_load(5'd6, 5'd2, 16'h000C);
      emit_store(proc_pkg::GRAN_WORD, 5'd6, 5'd0, 16'h0104);
      emit_halt();
      run_program();
   endtask

   task automatic test_errors();
      new_program();
      emit_addi(5'd1, 5'd0, 16'h0030);
      emit_addi(5'd2, 5'd0, 16'($urandom));
      emit_store(proc_pkg::GRAN_BAD, 5'd2, 5'd1, 16'h0000);
      emit_illegal(6'd9);
      emit_store(proc_pkg::GRAN_WORD, 5'd2, 5'd1, 16'h0004);
      emit_r(proc_pkg::OP_ADD, 5'd3, 5'd2, 5'd2);
      emit_store(proc_pkg::GRAN_WORD, 5'd3, 5'd1, 16'h0008);
      emit_halt();
      run_program();
   endtask

   task automatic test_halt();
      new_program();
      emit_addi(5'd1, 5'd0, 16'h0010);
      emit_store(proc_pkg::GRAN_WORD, 5'd1, 5'd0, 16'h0300);
      emit_halt();
      // Never fetched, so no store may come from these
      put_word({6'(proc_pkg::OP_ST_BASE), 5'd0, 5'd1, 16'h0304});
      put_word({6'(proc_pkg::OP_ST_BASE), 5'd0, 5'd1, 16'h0308});
      run_program();
   endtask

   initial begin
      void'($urandom(76278));
      rst_n = 1'b0;
      errors = 0;
      stores_seen = 0;
      err_seen = 0;
      new_program();
      test_alu_forwarding();
      test_byte_lanes();
      test_load_use();
      test_errors();
      test_halt();
      $display("Stores checked %0d, errors %0d", stores_seen, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
hdl/proc_pkg.sv
hdl/fetch_stage.sv
hdl/decode_ctrl.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/hazard_forward.sv
hdl/exec_stage.sv
hdl/mem_stage.sv
hdl/proc_top.sv
test/proc_checker.sv
test/proc_tb.sv

//--- run.sh
#!/bin/sh
# Build the pipeline testbench with Verilator, run it and scan the log

verilator --binary --assert -f flist.f --top-module proc_tb -Mdir obj_dir -o proc_sim \
   || { echo "Verilator build failed"; exit 1; }

./obj_dir/proc_sim > sim.log 2>&1 || echo "Simulator returned a nonzero status"
cat sim.log

grep -q "Result: FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "Simulation ended without a pass line"; exit 1; }
echo "Simulation finished cleanly"
